// File: common/riscvIsaPkg.sv
// RV64 instruction field types, opcode, funct3, funct7 and system code constants
package riscvIsaPkg;

  typedef logic [31:0] instrT;  // raw instruction word
  typedef logic [6:0]  opcodeT; // instr[6:0]
  typedef logic [2:0]  funct3T; // instr[14:12]
  typedef logic [6:0]  funct7T; // instr[31:25]
  typedef logic [11:0] sys12T;  // instr[31:20], system code or csr address

  // major opcodes
  localparam opcodeT OpLui     = 7'b0110111;
  localparam opcodeT OpAuipc   = 7'b0010111;
  localparam opcodeT OpJal     = 7'b1101111;
  localparam opcodeT OpJalr    = 7'b1100111;
  localparam opcodeT OpImm     = 7'b0010011; // addi .. srai
  localparam opcodeT OpReg     = 7'b0110011; // add .. and, mul/div/rem
  localparam opcodeT OpImm32   = 7'b0011011; // addiw, slliw, srliw, sraiw
  localparam opcodeT OpReg32   = 7'b0111011; // addw .. sraw, m word forms
  localparam opcodeT OpBranch  = 7'b1100011;
  localparam opcodeT OpLoad    = 7'b0000011;
  localparam opcodeT OpStore   = 7'b0100011;
  localparam opcodeT OpSystem  = 7'b1110011; // ecall, ebreak, mret, csr
  localparam opcodeT OpMiscMem = 7'b0001111; // fence.i only

  // funct3 values the decoders test by name
  localparam funct3T Funct3AddSub = 3'b000; // add/sub, mul for m
  localparam funct3T Funct3Sll    = 3'b001;
  localparam funct3T Funct3Sr     = 3'b101; // srl/sra split on bit 30
  localparam funct3T Funct3Priv   = 3'b000; // system privileged group

  // funct7 values
  localparam funct7T Funct7MulDiv = 7'b0000001; // m extension
  localparam funct7T Funct7Alt    = 7'b0100000; // sub, sra

  // system upper 12 bits when funct3 is Funct3Priv
  localparam sys12T Sys12Ecall  = 12'h000;
  localparam sys12T Sys12Ebreak = 12'h001;
  localparam sys12T Sys12Mret   = 12'h302;

endpackage

// File: common/decodeCtrlPkg.sv
// decode control codes, control field types and the packed control bundles
package decodeCtrlPkg;

  // bit 4 word form, bit 3 alternate form
  typedef logic [4:0] aluOpT;
  typedef logic [2:0] immTypeT;
  typedef logic [1:0] srcBT;
  typedef logic [1:0] mulOpT;
  typedef logic [2:0] branchT;
  typedef logic [2:0] memOpT;
  typedef logic [2:0] csrOpT;

  localparam aluOpT AluAdd   = 5'd0;
  localparam aluOpT AluSll   = 5'd1;
  localparam aluOpT AluSlt   = 5'd2;
  localparam aluOpT AluSltu  = 5'd3;
  localparam aluOpT AluXor   = 5'd4;
  localparam aluOpT AluSrl   = 5'd5;
  localparam aluOpT AluOr    = 5'd6;
  localparam aluOpT AluAnd   = 5'd7;
  localparam aluOpT AluSub   = 5'd8;
  localparam aluOpT AluMul   = 5'd9;
  localparam aluOpT AluDivu  = 5'd10;
  localparam aluOpT AluDiv   = 5'd11;
  localparam aluOpT AluRemu  = 5'd12;
  localparam aluOpT AluSra   = 5'd13;
  localparam aluOpT AluRem   = 5'd14;
  localparam aluOpT AluPassB = 5'd15; // lui, result is operand b
  localparam aluOpT AluAddW  = 5'd16;
  localparam aluOpT AluSllW  = 5'd17;
  localparam aluOpT AluSrlW  = 5'd21;
  localparam aluOpT AluSubW  = 5'd24;
  localparam aluOpT AluMulW  = 5'd25;
  localparam aluOpT AluDivuW = 5'd26;
  localparam aluOpT AluDivW  = 5'd27;
  localparam aluOpT AluRemuW = 5'd28;
  localparam aluOpT AluSraW  = 5'd29;
  localparam aluOpT AluRemW  = 5'd30;

  localparam immTypeT ImmI = 3'd0;
  localparam immTypeT ImmU = 3'd1;
  localparam immTypeT ImmS = 3'd2;
  localparam immTypeT ImmB = 3'd3;
  localparam immTypeT ImmJ = 3'd4;
  localparam immTypeT ImmR = 3'd5; // no immediate

  localparam logic SrcAPc  = 1'b0;
  localparam logic SrcAReg = 1'b1;

  localparam srcBT SrcBReg  = 2'd0;
  localparam srcBT SrcBImm  = 2'd1;
  localparam srcBT SrcBFour = 2'd2; // link address pc + 4

  localparam mulOpT MulLow = 2'd0; // mul, also signed default
  localparam mulOpT MulHu  = 2'd1;
  localparam mulOpT MulHsu = 2'd2;
  localparam mulOpT MulH   = 2'd3;

  localparam branchT BrNone = 3'd0;
  localparam branchT BrJal  = 3'd1;
  localparam branchT BrJalr = 3'd2;
  localparam branchT BrEq   = 3'd4;
  localparam branchT BrNe   = 3'd5;
  localparam branchT BrLt   = 3'd6; // blt, bltu via alu op
  localparam branchT BrGe   = 3'd7; // bge, bgeu via alu op

  localparam memOpT MemW  = 3'd0;
  localparam memOpT MemB  = 3'd1;
  localparam memOpT MemH  = 3'd2;
  localparam memOpT MemD  = 3'd3;
  localparam memOpT MemBu = 3'd4;
  localparam memOpT MemHu = 3'd5;
  localparam memOpT MemWu = 3'd6;

  localparam csrOpT CsrWrite = 3'd0;
  localparam csrOpT CsrSet   = 3'd1;
  localparam csrOpT CsrClear = 3'd2;

  typedef struct packed {
    logic  srcA; // 1 register, 0 pc
    srcBT  srcB;
    aluOpT aluOp;
    mulOpT mulOp;
  } exeCtrlT;

  typedef struct packed {
    immTypeT immType;
    branchT  branch;
    memOpT   memOp;
    logic    memWen;
    logic    memToReg;
    logic    rfWen;
    logic    ecall;
    logic    ebreak;
    logic    mret;
    logic    csrWen;
    csrOpT   csrOp;
    logic    csrToReg;
    logic    fenceI;
  } flowCtrlT;

  typedef struct packed {
    logic     illegal;
    exeCtrlT  exe;
    flowCtrlT flow;
  } decodeCtrlT;

  // control set for an illegal or unknown word, no side effects
  localparam exeCtrlT ExeDefault = '{srcA: SrcAReg, srcB: SrcBReg, aluOp: AluAdd,
                                     mulOp: MulLow};
  localparam flowCtrlT FlowDefault = '{immType: ImmI, branch: BrNone, memOp: MemW,
                                       memWen: 1'b0, memToReg: 1'b0, rfWen: 1'b0,
                                       ecall: 1'b0, ebreak: 1'b0, mret: 1'b0,
                                       csrWen: 1'b0, csrOp: CsrWrite, csrToReg: 1'b0,
                                       fenceI: 1'b0};

endpackage

// File: rtl/aluDecoder.sv
// aluDecoder: operand selects, ALU operation, multiply mode and opcode legality
`timescale 1ns/10ps

module aluDecoder
  import riscvIsaPkg::*;
  import decodeCtrlPkg::*;
(
  input  instrT   instr_i,
  output exeCtrlT exe_o,
  output logic    aluLegal_o
);

  opcodeT opcode;
  funct3T funct3;
  funct7T funct7;
  logic   altBit;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign altBit = instr_i[30]; // sra/sraw select for immediates

  always_comb begin
    exe_o      = ExeDefault; // reg, reg, add
    aluLegal_o = 1'b1;
    case (opcode)
      OpLui: begin
        exe_o.srcB  = SrcBImm;
        exe_o.aluOp = AluPassB; // rd = imm
      end
      OpAuipc: begin
        exe_o.srcA = SrcAPc;
        exe_o.srcB = SrcBImm;
      end
      OpJal, OpJalr: begin
        exe_o.srcA = SrcAPc; // link value pc + 4
        exe_o.srcB = SrcBFour;
      end
      OpImm: begin
        exe_o.srcB  = SrcBImm;
        exe_o.aluOp = aluOpT'({2'b00, funct3}); // op code is funct3
        if (funct3 == Funct3Sr && altBit) begin
          exe_o.aluOp = AluSra;
        end
      end
      OpReg: begin
        if (funct7 == Funct7MulDiv) begin
          case (funct3)
            3'd0: exe_o.aluOp = AluMul;
            3'd1: begin
              exe_o.aluOp = AluMul;
              exe_o.mulOp = MulH;
            end
            3'd2: begin
              exe_o.aluOp = AluMul;
              exe_o.mulOp = MulHsu;
            end
            3'd3: begin
              exe_o.aluOp = AluMul;
              exe_o.mulOp = MulHu;
            end
            3'd4:    exe_o.aluOp = AluDiv;
            3'd5:    exe_o.aluOp = AluDivu;
            3'd6:    exe_o.aluOp = AluRem;
            default: exe_o.aluOp = AluRemu;
          endcase
        end else begin
          exe_o.aluOp = aluOpT'({2'b00, funct3});
          if (funct3 == Funct3AddSub && funct7 == Funct7Alt) begin
            exe_o.aluOp = AluSub;
          end else if (funct3 == Funct3Sr && altBit) begin
            exe_o.aluOp = AluSra;
          end
        end
      end
      OpImm32: begin
        exe_o.srcB = SrcBImm;
        case (funct3)
          Funct3AddSub: exe_o.aluOp = AluAddW;
          Funct3Sll:    exe_o.aluOp = AluSllW;
          default:      exe_o.aluOp = altBit ? AluSraW : AluSrlW;
        endcase
      end
      OpReg32: begin
        if (funct7 == Funct7MulDiv) begin
          case (funct3) // word mul has no high half
            3'd4:    exe_o.aluOp = AluDivW;
            3'd5:    exe_o.aluOp = AluDivuW;
            3'd6:    exe_o.aluOp = AluRemW;
            3'd7:    exe_o.aluOp = AluRemuW;
            default: exe_o.aluOp = AluMulW;
          endcase
        end else begin
          case (funct3)
            Funct3AddSub: exe_o.aluOp = (funct7 == Funct7Alt) ? AluSubW : AluAddW;
            Funct3Sll:    exe_o.aluOp = AluSllW;
            default:      exe_o.aluOp = altBit ? AluSraW : AluSrlW;
          endcase
        end
      end
      OpBranch: begin
        // compare result feeds the branch unit
        exe_o.aluOp = (funct3[2:1] == 2'b11) ? AluSltu : AluSlt;
      end
      OpLoad, OpStore, OpSystem: begin
        exe_o.srcB = SrcBImm; // address or csr operand
      end
      OpMiscMem: begin
        exe_o = ExeDefault; // fence.i, alu idle
      end
      default: begin
        aluLegal_o = 1'b0; // unknown opcode
      end
    endcase
  end

endmodule

// File: rtl/flowDecoder.sv
// flowDecoder: immediate format, branch, memory, write-back and system controls
`timescale 1ns/10ps

module flowDecoder
  import riscvIsaPkg::*;
  import decodeCtrlPkg::*;
(
  input  instrT    instr_i,
  output flowCtrlT flow_o,
  output logic     flowFault_o
);

  opcodeT opcode;
  funct3T funct3;
  sys12T  sys12;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign sys12  = instr_i[31:20];

  // access size from load/store funct3
  function automatic memOpT memSize(input funct3T f3);
    memOpT size;
    case (f3)
      3'd0:    size = MemB;
      3'd1:    size = MemH;
      3'd2:    size = MemW;
      3'd3:    size = MemD;
      3'd4:    size = MemBu;
      3'd5:    size = MemHu;
      3'd6:    size = MemWu;
      default: size = MemW; // no such load
    endcase
    return size;
  endfunction

  always_comb begin
    flow_o      = FlowDefault;
    flowFault_o = 1'b0;
    case (opcode)
      OpLui, OpAuipc: begin
        flow_o.immType = ImmU;
        flow_o.rfWen   = 1'b1;
      end
      OpJal: begin
        flow_o.immType = ImmJ;
        flow_o.branch  = BrJal;
        flow_o.rfWen   = 1'b1; // link
      end
      OpJalr: begin
        flow_o.branch = BrJalr;
        flow_o.rfWen  = 1'b1;
      end
      OpImm, OpImm32: begin
        flow_o.rfWen = 1'b1;
      end
      OpReg, OpReg32: begin
        flow_o.immType = ImmR;
        flow_o.rfWen   = 1'b1;
      end
      OpBranch: begin
        flow_o.immType = ImmB;
        case (funct3)
          3'd0:    flow_o.branch = BrEq;
          3'd1:    flow_o.branch = BrNe;
          3'd4,
          3'd6:    flow_o.branch = BrLt; // signed or unsigned from alu op
          3'd5,
          3'd7:    flow_o.branch = BrGe;
          default: flowFault_o = 1'b1; // funct3 2, 3
        endcase
      end
      OpLoad: begin
        flow_o.memOp    = memSize(funct3);
        flow_o.memToReg = 1'b1;
        flow_o.rfWen    = 1'b1;
        flowFault_o     = (funct3 == 3'd7);
      end
      OpStore: begin
        flow_o.immType = ImmS;
        flow_o.memOp   = memSize(funct3);
        flow_o.memWen  = 1'b1;
        flowFault_o    = funct3[2]; // sb, sh, sw, sd only
      end
      OpSystem: begin
        if (funct3 == Funct3Priv) begin
          case (sys12) // no write-back for traps
            Sys12Ecall:  flow_o.ecall  = 1'b1;
            Sys12Ebreak: flow_o.ebreak = 1'b1;
            Sys12Mret:   flow_o.mret   = 1'b1;
            default:     flowFault_o   = 1'b1;
          endcase
        end else if (!funct3[2]) begin
          // csrrw, csrrs, csrrc map to 0, 1, 2
          flow_o.csrWen   = 1'b1;
          flow_o.csrOp    = csrOpT'({1'b0, funct3[1:0]} - 3'd1);
          flow_o.csrToReg = 1'b1; // old csr value to rd
          flow_o.rfWen    = 1'b1;
        end else begin
          flowFault_o = 1'b1; // immediate csr forms not supported
        end
      end
      OpMiscMem: begin
        flow_o.fenceI = 1'b1;
      end
      default: begin
        flow_o = FlowDefault; // legality comes from aluDecoder
      end
    endcase
  end

endmodule

// File: rtl/decodeStage.sv
// decodeStage: merges both decoders, applies the illegal override, registers the bundle
`timescale 1ns/10ps

module decodeStage
  import riscvIsaPkg::*;
  import decodeCtrlPkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  instrT      instr_i,
  input  logic       instrValid_i,
  output decodeCtrlT ctrl_o,
  output logic       ctrlValid_o
);

  exeCtrlT    exe;
  flowCtrlT   flow;
  logic       aluLegal;
  logic       flowFault;
  decodeCtrlT ctrlNext;

  // both decoders look at the same word in parallel
  aluDecoder i_aluDecoder (
    .instr_i    (instr_i),
    .exe_o      (exe),
    .aluLegal_o (aluLegal)
  );

  flowDecoder i_flowDecoder (
    .instr_i     (instr_i),
    .flow_o      (flow),
    .flowFault_o (flowFault)
  );

  always_comb begin
    ctrlNext.illegal = ~aluLegal | flowFault;
    if (ctrlNext.illegal) begin
      ctrlNext.exe  = ExeDefault;  // reg, reg, add
      ctrlNext.flow = FlowDefault; // all writes off
    end else begin
      ctrlNext.exe  = exe;
      ctrlNext.flow = flow;
    end
  end

  // one cycle stage, no stall path
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_o      <= '0;
      ctrlValid_o <= 1'b0;
    end else begin
      ctrlValid_o <= instrValid_i;
      if (instrValid_i) begin
        ctrl_o <= ctrlNext; // holds across gaps
      end
    end
  end

endmodule

// File: testbench/decodeStage_props.sv
// decodeStageProps: concurrent checks on the registered decode bundle, bound to decodeStage
`timescale 1ns/10ps

module decodeStageProps
  import decodeCtrlPkg::*;
(
  input logic       clk_i,
  input logic       reset_i,
  input decodeCtrlT ctrl_i,
  input logic       ctrlValid_i
);

  logic anyEnable;
  int   assertFails = 0; // failed property count

  assign anyEnable = ctrl_i.flow.memWen | ctrl_i.flow.memToReg | ctrl_i.flow.rfWen
                   | ctrl_i.flow.csrWen | ctrl_i.flow.csrToReg | ctrl_i.flow.ecall
                   | ctrl_i.flow.ebreak | ctrl_i.flow.mret | ctrl_i.flow.fenceI;

  validLowInReset: assert property (@(posedge clk_i) reset_i |=> !ctrlValid_i)
    else begin
      assertFails = assertFails + 1;
      $error("ctrlValid_o high after a reset cycle");
    end

  storeNoWriteBack: assert property (@(posedge clk_i) disable iff (reset_i)
    !(ctrl_i.flow.memWen && ctrl_i.flow.rfWen))
    else begin
      assertFails = assertFails + 1;
      $error("memWen and rfWen both set");
    end

  illegalQuiet: assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_i.illegal |-> !anyEnable)
    else begin
      assertFails = assertFails + 1;
      $error("illegal bundle with an enable set");
    end

  csrReadWrites: assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_i.flow.csrToReg |-> ctrl_i.flow.rfWen)
    else begin
      assertFails = assertFails + 1;
      $error("csrToReg without rfWen");
    end

endmodule

bind decodeStage decodeStageProps i_props (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .ctrl_i      (ctrl_o),
  .ctrlValid_i (ctrlValid_o)
);

// File: testbench/decodeStageTb.sv
// decodeStageTb: clock, reset, random instruction stimulus, reference decode model and checker
`timescale 1ns/10ps

module decodeStageTb
  import riscvIsaPkg::*;
  import decodeCtrlPkg::*;
();

  localparam int TimeoutCycles = 2000 + 200; // all phases plus reset and margin

  logic       clk = 1'b0;
  logic       reset;
  instrT      instr;
  logic       instrValid;
  decodeCtrlT ctrl;
  logic       ctrlValid;

  decodeCtrlT expCtrlQ[$];  // one word in flight
  logic       expValidQ[$];
  decodeCtrlT holdCtrl = '0; // last valid bundle, held across gaps
  instrT      lastWord = '0;
  int         cycleCount = 0;

  decodeStage i_dut (
    .clk_i        (clk),
    .reset_i      (reset),
    .instr_i      (instr),
    .instrValid_i (instrValid),
    .ctrl_o       (ctrl),
    .ctrlValid_o  (ctrlValid)
  );

  always #2 clk = ~clk; // 4 ns period

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s expected %h actual %h", name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // expected bundle from the ISA decode rules
  function automatic decodeCtrlT expectCtrl(input instrT w);
    decodeCtrlT c;
    aluOpT      op;
    funct3T     f3;
    logic       alt;
    logic       md;
    logic       isReg;
    logic       isWord;
    logic       bad;
    f3  = w[14:12];
    alt = w[30];
    md  = (w[31:25] == Funct7MulDiv);
    bad = 1'b0;
    c   = '0;
    c.exe.srcA = 1'b1; // register unless pc based
    case (w[6:0])
      OpLui: begin
        c.exe.srcB     = SrcBImm;
        c.exe.aluOp    = AluPassB;
        c.flow.immType = ImmU;
        c.flow.rfWen   = 1'b1;
      end
      OpAuipc: begin
        c.exe.srcA     = 1'b0;
        c.exe.srcB     = SrcBImm;
        c.flow.immType = ImmU;
        c.flow.rfWen   = 1'b1;
      end
      OpJal, OpJalr: begin
        c.exe.srcA     = 1'b0;
        c.exe.srcB     = SrcBFour; // link = pc + 4
        c.flow.immType = (w[6:0] == OpJal) ? ImmJ : ImmI;
        c.flow.branch  = (w[6:0] == OpJal) ? BrJal : BrJalr;
        c.flow.rfWen   = 1'b1;
      end
      OpImm, OpReg, OpImm32, OpReg32: begin
        isReg  = w[5]; // register forms have opcode bit 5
        isWord = w[3]; // 32-bit forms have opcode bit 3
        c.exe.srcB     = isReg ? SrcBReg : SrcBImm;
        c.flow.immType = isReg ? ImmR : ImmI;
        c.flow.rfWen   = 1'b1;
        if (isReg && md) begin
          case (f3)
            3'd4:    op = AluDiv;
            3'd5:    op = AluDivu;
            3'd6:    op = AluRem;
            3'd7:    op = AluRemu;
            default: op = AluMul;
          endcase
          if (!isWord) begin
            case (f3)
              3'd1:    c.exe.mulOp = MulH;
              3'd2:    c.exe.mulOp = MulHsu;
              3'd3:    c.exe.mulOp = MulHu;
              default: c.exe.mulOp = MulLow;
            endcase
          end
        end else if (f3 == 3'd0) begin
          op = (isReg && w[31:25] == Funct7Alt) ? AluSub : AluAdd;
        end else if (isWord && f3 != 3'd1) begin
          op = alt ? AluSra : AluSrl; // word set has add, sll, shift right only
        end else if (f3 == 3'd5 && alt) begin
          op = AluSra;
        end else begin
          op = aluOpT'({2'b00, f3});
        end
        if (isWord) begin
          op[4] = 1'b1; // word form
        end
        c.exe.aluOp = op;
      end
      OpBranch: begin
        c.exe.aluOp    = (f3 >= 3'd6) ? AluSltu : AluSlt;
        c.flow.immType = ImmB;
        case (f3)
          3'd0:       c.flow.branch = BrEq;
          3'd1:       c.flow.branch = BrNe;
          3'd4, 3'd6: c.flow.branch = BrLt;
          3'd5, 3'd7: c.flow.branch = BrGe;
          default:    bad = 1'b1;
        endcase
      end
      OpLoad, OpStore: begin
        c.exe.srcB = SrcBImm; // base + offset
        case (f3)
          3'd0:    c.flow.memOp = MemB;
          3'd1:    c.flow.memOp = MemH;
          3'd2:    c.flow.memOp = MemW;
          default: c.flow.memOp = memOpT'(f3); // d, bu, hu, wu keep funct3
        endcase
        if (w[6:0] == OpLoad) begin
          c.flow.memToReg = 1'b1;
          c.flow.rfWen    = 1'b1;
          bad             = (f3 == 3'd7);
        end else begin
          c.flow.immType = ImmS;
          c.flow.memWen  = 1'b1;
          bad            = (f3 >= 3'd4);
        end
      end
      OpSystem: begin
        c.exe.srcB = SrcBImm;
        if (f3 == 3'd0) begin
          c.flow.ecall  = (w[31:20] == Sys12Ecall);
          c.flow.ebreak = (w[31:20] == Sys12Ebreak);
          c.flow.mret   = (w[31:20] == Sys12Mret);
          bad = !(c.flow.ecall || c.flow.ebreak || c.flow.mret);
        end else if (f3 < 3'd4) begin
          c.flow.csrWen   = 1'b1;
          case (f3)
            3'd1:    c.flow.csrOp = CsrWrite; // csrrw
            3'd2:    c.flow.csrOp = CsrSet;   // csrrs
            default: c.flow.csrOp = CsrClear; // csrrc
          endcase
          c.flow.csrToReg = 1'b1;
          c.flow.rfWen    = 1'b1;
        end else begin
          bad = 1'b1;
        end
      end
      OpMiscMem: c.flow.fenceI = 1'b1;
      default:   bad = 1'b1; // unknown opcode
    endcase
    if (bad) begin
      c            = '0; // no writes, no side effects
      c.exe.srcA   = 1'b1;
      c.illegal    = 1'b1;
    end
    return c;
  endfunction

  function automatic opcodeT opcodeAt(input int idx);
    case (idx)
      0:  return OpLui;
      1:  return OpAuipc;
      2:  return OpJal;
      3:  return OpJalr;
      4:  return OpImm;
      5:  return OpReg;
      6:  return OpImm32;
      7:  return OpReg32;
      8:  return OpBranch;
      9:  return OpLoad;
      10: return OpStore;
      11: return OpSystem;
      default: return OpMiscMem;
    endcase
  endfunction

  // random word, opcode pool picked by phase
  function automatic instrT makeWord(input int phase);
    instrT       w;
    logic [31:0] r;
    int          idx;
    w = $urandom;
    r = $urandom;
    case (phase)
      0:       idx = $urandom_range(0, 7);  // alu classes
      1:       idx = $urandom_range(8, 10); // branch, load, store
      2:       idx = $urandom_range(11, 12); // system, misc-mem
      default: idx = $urandom_range(0, 12);
    endcase
    w[6:0] = opcodeAt(idx);
    case ($urandom_range(0, 3))
      0: w[31:25] = 7'b0;
      1: w[31:25] = Funct7Alt;
      2: w[31:25] = Funct7MulDiv;
      default: ; // random funct7
    endcase
    if (w[6:0] == OpSystem) begin
      if ($urandom_range(0, 1) == 0) begin
        w[14:12] = 3'd0; // more trap codes
      end
      case ($urandom_range(0, 3))
        0: w[31:20] = Sys12Ecall;
        1: w[31:20] = Sys12Ebreak;
        2: w[31:20] = Sys12Mret;
        default: ;
      endcase
    end
    if ($urandom_range(0, 15) == 0) begin
      w[6:0] = r[6:0]; // random opcode
    end
    return w;
  endfunction

  task automatic compareOutputs(input string name);
    decodeCtrlT exp;
    logic       expValid;
    exp      = expCtrlQ.pop_front();
    expValid = expValidQ.pop_front();
    checkValue($sformatf("%s valid word %h", name, lastWord), 32'(expValid), 32'(ctrlValid));
    checkValue($sformatf("%s illegal word %h", name, lastWord), 32'(exp.illegal),
               32'(ctrl.illegal));
    checkValue($sformatf("%s exe word %h", name, lastWord), 32'(exp.exe), 32'(ctrl.exe));
    checkValue($sformatf("%s flow word %h", name, lastWord), 32'(exp.flow), 32'(ctrl.flow));
  endtask

  // one word per cycle, back to back, gaps only in phase 3
  task automatic runPhase(input string name, input int phase, input int count);
    instrT w;
    logic  v;
    repeat (count) begin
      @(posedge clk);
      #1;
      compareOutputs(name);
      w = makeWord(phase);
      v = (phase != 3) || ($urandom_range(0, 3) != 0);
      instr      = w;
      instrValid = v;
      lastWord   = w;
      if (v) begin
        holdCtrl = expectCtrl(w);
      end
      expValidQ.push_back(v);
      expCtrlQ.push_back(holdCtrl);
    end
  endtask

  initial begin
    void'($urandom(32'h813));
    reset      = 1'b1;
    instr      = '0;
    instrValid = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    checkValue("reset valid", 32'(1'b0), 32'(ctrlValid));
    checkValue("reset bundle", 32'(0), 32'(ctrl));
    expValidQ.push_back(1'b0); // idle cycle after reset
    expCtrlQ.push_back('0);
    runPhase("alu classes", 0, 600);
    runPhase("branch load store", 1, 500);
    runPhase("system misc-mem", 2, 400);
    runPhase("mixed with gaps", 3, 500);
    @(posedge clk);
    #1;
    compareOutputs("drain");
    if (i_dut.i_props.assertFails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: decodeStage.f
common/riscvIsaPkg.sv
common/decodeCtrlPkg.sv
rtl/aluDecoder.sv
rtl/flowDecoder.sv
rtl/decodeStage.sv
testbench/decodeStage_props.sv
testbench/decodeStageTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Verilator build and run of the decode stage testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module decodeStageTb -f decodeStage.f \
  -o decodeStageSim \
  && ./obj_dir/decodeStageSim | tee /dev/stderr | grep -q "Testbench passed" \
  && echo "simulation ok" \
  || { echo "simulation not ok"; exit 1; }
